/* verilog/mips_define.sv */
package mips_define;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL  = 6'b000000;
    localparam logic [5:0] OP_SPECIAL3 = 6'b011111;
    localparam logic [5:0] OP_ADDIU    = 6'b001001;
    localparam logic [5:0] OP_DADDIU   = 6'b011001;
    localparam logic [5:0] OP_SLTI     = 6'b001010;
    localparam logic [5:0] OP_SLTIU    = 6'b001011;
    localparam logic [5:0] OP_ANDI     = 6'b001100;
    localparam logic [5:0] OP_ORI      = 6'b001101;
    localparam logic [5:0] OP_XORI     = 6'b001110;
    localparam logic [5:0] OP_LUI      = 6'b001111;

    // SPECIAL funct field
    localparam logic [5:0] OP0_ADDU    = 6'b100001;
    localparam logic [5:0] OP0_DADDU   = 6'b101101;
    localparam logic [5:0] OP0_SUBU    = 6'b100011;
    localparam logic [5:0] OP0_DSUBU   = 6'b101111;
    localparam logic [5:0] OP0_AND     = 6'b100100;
    localparam logic [5:0] OP0_OR      = 6'b100101;
    localparam logic [5:0] OP0_XOR     = 6'b100110;
    localparam logic [5:0] OP0_NOR     = 6'b100111;
    localparam logic [5:0] OP0_SLT     = 6'b101010;
    localparam logic [5:0] OP0_SLTU    = 6'b101011;
    localparam logic [5:0] OP0_SLL     = 6'b000000;
    localparam logic [5:0] OP0_SRL     = 6'b000010;
    localparam logic [5:0] OP0_SRA     = 6'b000011;
    localparam logic [5:0] OP0_DSLL    = 6'b111000;
    localparam logic [5:0] OP0_DSRL    = 6'b111010;
    localparam logic [5:0] OP0_DSRA    = 6'b111011;
    localparam logic [5:0] OP0_DSLL32  = 6'b111100;
    localparam logic [5:0] OP0_DSRL32  = 6'b111110;
    localparam logic [5:0] OP0_LSA     = 6'b000101;
    localparam logic [5:0] OP0_DLSA    = 6'b010101;

    // SPECIAL3 bshfl group, selected by the shamt field
    localparam logic [5:0] OP3_FUNC_BSHFL = 6'b100000;
    localparam logic [4:0] OP3_SEB        = 5'b10000;
    localparam logic [4:0] OP3_SEH        = 5'b11000;

endpackage

/* verilog/structures.sv */
package structures;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [1:0] {B_REG, B_SIMM, B_ZIMM} alu_b_src_t;

    // shifter output feeds the adder for lsa
    typedef enum logic {A_REG, A_SHIFT} alu_a_src_t;

    typedef enum logic [1:0] {OUT_ALU, OUT_BARREL, OUT_LUI} ex_out_src_t;

    // low word kept, upper word filled by sign or zero
    typedef enum logic [1:0] {CUT_NONE, CUT_SEXT, CUT_ZEXT} cut_t;

    typedef enum logic [1:0] {EXT_NONE, EXT_SEB, EXT_SEH} ext_src_t;

    typedef enum logic [1:0] {
        P32_NONE, P32_LO_TO_HI, P32_HI_TO_LO, P32_SWAP
    } plus32_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_u;

endpackage

/* verilog/ex_ctrl_if.sv */
`timescale 1ns/10ps

interface ex_ctrl_if import structures::*; ();

    logic        valid;
    logic        except;
    logic [4:0]  wb_addr;
    logic        write_enable;
    alu_op_t     alu_op;
    alu_a_src_t  alu_a_src;
    alu_b_src_t  alu_b_src;
    logic [15:0] imm;
    logic [4:0]  shamt;
    logic        barrel_right;
    logic        barrel_rotate;
    logic        shift_arith;
    plus32_t     barrel_plus32;
    logic        barrel_src;
    cut_t        cut_alu;
    cut_t        cut_barrel;
    ext_src_t    ext_src;
    ex_out_src_t ex_out_src;

    modport decoder (
        output valid, except, wb_addr, write_enable, alu_op, alu_a_src, alu_b_src, imm,
        output shamt, barrel_right, barrel_rotate, shift_arith, barrel_plus32, barrel_src,
        output cut_alu, cut_barrel, ext_src, ex_out_src
    );

    modport datapath (
        input valid, except, wb_addr, write_enable, alu_op, alu_a_src, alu_b_src, imm,
        input shamt, barrel_right, barrel_rotate, shift_arith, barrel_plus32, barrel_src,
        input cut_alu, cut_barrel, ext_src, ex_out_src
    );

endinterface

/* verilog/mips_decoder.sv */
`timescale 1ns/10ps

module mips_decoder
    import mips_define::*;
    import structures::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       inst_valid,
    input  inst_word_u inst,
    output logic [4:0] rs_addr,
    output logic [4:0] rt_addr,
    ex_ctrl_if.decoder ctrl
);

    logic op0, op3, no_shamt, no_rs, rot_rs, nop_inst;
    logic addu_inst, daddu_inst, addiu_inst, daddiu_inst, add_family;
    logic subu_inst, dsubu_inst, sub_family;
    logic and_inst, andi_inst, or_inst, ori_inst, xor_inst, xori_inst, nor_inst, logic_family;
    logic slt_inst, slti_inst, sltu_inst, sltiu_inst, slt_family;
    logic sll_inst, dsll_inst, dsll32_inst, sll_family;
    logic srl_inst, dsrl_inst, dsrl32_inst, srl_family;
    logic sra_inst, dsra_inst, sra_family;
    logic rotr_inst, drotr_inst, drotr32_inst, rotr_family;
    logic lsa_inst, dlsa_inst, lsa_family;
    logic seb_inst, seh_inst, se_family;
    logic lui_inst, imm_form, word_shift, except;

    assign rs_addr = inst.r.rs;
    assign rt_addr = inst.r.rt;

    always_comb begin
        op0 = (inst.r.opcode == OP_SPECIAL);
        op3 = (inst.r.opcode == OP_SPECIAL3);
        no_shamt = (inst.r.shamt == 5'd0);
        no_rs = (inst.r.rs == 5'd0);
        // rotates reuse the srl encodings with rs = 1
        rot_rs = (inst.r.rs == 5'd1);
        nop_inst = (inst == 32'd0);

        addu_inst = op0 && (inst.r.funct == OP0_ADDU) && no_shamt;
        daddu_inst = op0 && (inst.r.funct == OP0_DADDU) && no_shamt;
        addiu_inst = (inst.i.opcode == OP_ADDIU);
        daddiu_inst = (inst.i.opcode == OP_DADDIU);
        add_family = addu_inst || daddu_inst || addiu_inst || daddiu_inst;

        subu_inst = op0 && (inst.r.funct == OP0_SUBU) && no_shamt;
        dsubu_inst = op0 && (inst.r.funct == OP0_DSUBU) && no_shamt;
        sub_family = subu_inst || dsubu_inst;

        and_inst = op0 && (inst.r.funct == OP0_AND) && no_shamt;
        or_inst = op0 && (inst.r.funct == OP0_OR) && no_shamt;
        xor_inst = op0 && (inst.r.funct == OP0_XOR) && no_shamt;
        nor_inst = op0 && (inst.r.funct == OP0_NOR) && no_shamt;
        andi_inst = (inst.i.opcode == OP_ANDI);
        ori_inst = (inst.i.opcode == OP_ORI);
        xori_inst = (inst.i.opcode == OP_XORI);
        logic_family = and_inst || or_inst || xor_inst || nor_inst
                    || andi_inst || ori_inst || xori_inst;

        slt_inst = op0 && (inst.r.funct == OP0_SLT) && no_shamt;
        sltu_inst = op0 && (inst.r.funct == OP0_SLTU) && no_shamt;
        slti_inst = (inst.i.opcode == OP_SLTI);
        sltiu_inst = (inst.i.opcode == OP_SLTIU);
        slt_family = slt_inst || sltu_inst || slti_inst || sltiu_inst;

        // the all-zero word is sll $0,$0,0 and stays unsupported
        sll_inst = op0 && (inst.r.funct == OP0_SLL) && no_rs && !nop_inst;
        dsll_inst = op0 && (inst.r.funct == OP0_DSLL) && no_rs;
        dsll32_inst = op0 && (inst.r.funct == OP0_DSLL32) && no_rs;
        sll_family = sll_inst || dsll_inst || dsll32_inst;

        srl_inst = op0 && (inst.r.funct == OP0_SRL) && no_rs;
        dsrl_inst = op0 && (inst.r.funct == OP0_DSRL) && no_rs;
        dsrl32_inst = op0 && (inst.r.funct == OP0_DSRL32) && no_rs;
        srl_family = srl_inst || dsrl_inst || dsrl32_inst;

        sra_inst = op0 && (inst.r.funct == OP0_SRA) && no_rs;
        dsra_inst = op0 && (inst.r.funct == OP0_DSRA) && no_rs;
        sra_family = sra_inst || dsra_inst;

        rotr_inst = op0 && (inst.r.funct == OP0_SRL) && rot_rs;
        drotr_inst = op0 && (inst.r.funct == OP0_DSRL) && rot_rs;
        drotr32_inst = op0 && (inst.r.funct == OP0_DSRL32) && rot_rs;
        rotr_family = rotr_inst || drotr_inst || drotr32_inst;

        // sa sits in bits 7:6, bits 10:8 must be zero
        lsa_inst = op0 && (inst.r.funct == OP0_LSA) && (inst.r.shamt[4:2] == 3'd0);
        dlsa_inst = op0 && (inst.r.funct == OP0_DLSA) && (inst.r.shamt[4:2] == 3'd0);
        lsa_family = lsa_inst || dlsa_inst;

        seb_inst = op3 && no_rs && (inst.r.shamt == OP3_SEB) && (inst.r.funct == OP3_FUNC_BSHFL);
        seh_inst = op3 && no_rs && (inst.r.shamt == OP3_SEH) && (inst.r.funct == OP3_FUNC_BSHFL);
        se_family = seb_inst || seh_inst;

        lui_inst = (inst.i.opcode == OP_LUI) && no_rs;

        imm_form = addiu_inst || daddiu_inst || slti_inst || sltiu_inst
                || andi_inst || ori_inst || xori_inst || lui_inst;
        word_shift = sll_inst || srl_inst || sra_inst || rotr_inst;

        except = !(add_family || sub_family || logic_family || slt_family || sll_family
                || srl_family || sra_family || rotr_family || lsa_family || se_family
                || lui_inst);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl.valid <= 1'b0;
            ctrl.except <= 1'b0;
            ctrl.write_enable <= 1'b0;
        end else begin
            ctrl.valid <= inst_valid;
            if (inst_valid) begin
                ctrl.except <= except;
                ctrl.write_enable <= !except;
            end
        end
    end

    // execute payload, only meaningful while valid is high
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            ctrl.wb_addr <= imm_form ? inst.i.rt : inst.r.rd;
            ctrl.imm <= inst.i.imm16;
            // seb and seh hold their code in shamt, operand B must pass unshifted
            ctrl.shamt <= se_family ? 5'd0 : inst.r.shamt;
            ctrl.alu_op <= sub_family ? ALU_SUB :
                           (and_inst || andi_inst) ? ALU_AND :
                           (or_inst || ori_inst) ? ALU_OR :
                           (xor_inst || xori_inst) ? ALU_XOR :
                           nor_inst ? ALU_NOR :
                           (slt_inst || slti_inst) ? ALU_SLT :
                           (sltu_inst || sltiu_inst) ? ALU_SLTU : ALU_ADD;
            ctrl.alu_a_src <= lsa_family ? A_SHIFT : A_REG;
            ctrl.alu_b_src <= (addiu_inst || daddiu_inst || slti_inst || sltiu_inst) ? B_SIMM :
                              (andi_inst || ori_inst || xori_inst) ? B_ZIMM : B_REG;
            ctrl.barrel_right <= srl_family || sra_family || rotr_family;
            ctrl.barrel_rotate <= rotr_family;
            ctrl.shift_arith <= sra_family;
            ctrl.barrel_plus32 <= dsll32_inst ? P32_LO_TO_HI :
                                  dsrl32_inst ? P32_HI_TO_LO :
                                  drotr32_inst ? P32_SWAP : P32_NONE;
            ctrl.barrel_src <= lsa_family;
            ctrl.cut_alu <= (addu_inst || subu_inst || addiu_inst || lsa_inst) ? CUT_SEXT
                                                                               : CUT_NONE;
            ctrl.cut_barrel <= word_shift ? CUT_SEXT : CUT_NONE;
            ctrl.ext_src <= seb_inst ? EXT_SEB : seh_inst ? EXT_SEH : EXT_NONE;
            ctrl.ex_out_src <= lui_inst ? OUT_LUI :
                               (sll_family || srl_family || sra_family || rotr_family
                                || se_family) ? OUT_BARREL : OUT_ALU;
        end
    end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [63:0] wr_data,
    output logic [63:0] a_data,
    output logic [63:0] b_data
);

    logic [63:0] regs [32];

    // same-edge write from the instruction ahead wins over the array
    function automatic logic [63:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 64'd0;
        end
        if (wr_en && (wr_addr == addr)) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 64'd0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        a_data <= read_port(rs_addr);
        b_data <= read_port(rt_addr);
    end

endmodule

/* verilog/barrel_shifter.sv */
`timescale 1ns/10ps

module barrel_shifter import structures::*; (
    ex_ctrl_if.datapath ctrl,
    input  logic [63:0] a_data,
    input  logic [63:0] b_data,
    output logic [63:0] shift_out
);

    logic [63:0]  src;
    logic [63:0]  staged;
    logic [5:0]   amount;
    logic [127:0] rot_full;

    always_comb begin
        src = ctrl.barrel_src ? a_data : b_data;

        // word shifts see only the low word, upper half prepared per kind
        if (ctrl.cut_barrel != CUT_NONE) begin
            if (ctrl.barrel_rotate) begin
                src[63:32] = src[31:0];
            end else if (ctrl.shift_arith) begin
                src[63:32] = {32{src[31]}};
            end else begin
                src[63:32] = 32'd0;
            end
        end

        case (ctrl.barrel_plus32)
            P32_LO_TO_HI: staged = {src[31:0], 32'd0};
            P32_HI_TO_LO: staged = {32'd0, src[63:32]};
            P32_SWAP:     staged = {src[31:0], src[63:32]};
            default:      staged = src;
        endcase

        // lsa shifts by sa + 1
        if (ctrl.barrel_src) begin
            amount = {4'd0, ctrl.shamt[1:0]} + 6'd1;
        end else begin
            amount = {1'b0, ctrl.shamt};
        end

        rot_full = {staged, staged} >> amount;

        if (!ctrl.barrel_right) begin
            shift_out = staged << amount;
        end else if (ctrl.barrel_rotate) begin
            shift_out = rot_full[63:0];
        end else if (ctrl.shift_arith) begin
            shift_out = $signed(staged) >>> amount;
        end else begin
            shift_out = staged >> amount;
        end
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/10ps

module alu import structures::*; (
    ex_ctrl_if.datapath ctrl,
    input  logic [63:0] a_data,
    input  logic [63:0] b_data,
    input  logic [63:0] shift_out,
    output logic [63:0] alu_out
);

    logic [63:0] op_a;
    logic [63:0] op_b;

    always_comb begin
        op_a = (ctrl.alu_a_src == A_SHIFT) ? shift_out : a_data;

        case (ctrl.alu_b_src)
            B_SIMM:  op_b = {{48{ctrl.imm[15]}}, ctrl.imm};
            B_ZIMM:  op_b = {48'd0, ctrl.imm};
            default: op_b = b_data;
        endcase

        case (ctrl.alu_op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_NOR:  alu_out = ~(op_a | op_b);
            ALU_SLT:  alu_out = {63'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {63'd0, op_a < op_b};
            default:  alu_out = op_a + op_b;
        endcase
    end

endmodule

/* verilog/result_unit.sv */
`timescale 1ns/10ps

module result_unit import structures::*; (
    input  logic        clk,
    input  logic        rst_n,
    ex_ctrl_if.datapath ctrl,
    input  logic [63:0] alu_out,
    input  logic [63:0] shift_out,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [63:0] wr_data,
    output logic        wb_valid,
    output logic [4:0]  wb_addr,
    output logic [63:0] wb_data,
    output logic        except
);

    logic [63:0] selected;
    logic [63:0] cut_value;
    logic [63:0] result;
    cut_t        cut_sel;

    always_comb begin
        case (ctrl.ex_out_src)
            OUT_BARREL: selected = shift_out;
            // lui result is already the sign-extended upper half
            OUT_LUI:    selected = {{32{ctrl.imm[15]}}, ctrl.imm, 16'd0};
            default:    selected = alu_out;
        endcase

        cut_sel = (ctrl.ex_out_src == OUT_ALU) ? ctrl.cut_alu : ctrl.cut_barrel;
        case (cut_sel)
            CUT_SEXT: cut_value = {{32{selected[31]}}, selected[31:0]};
            CUT_ZEXT: cut_value = {32'd0, selected[31:0]};
            default:  cut_value = selected;
        endcase

        // seb and seh arrive as unshifted operand B
        case (ctrl.ext_src)
            EXT_SEB: result = {{56{cut_value[7]}}, cut_value[7:0]};
            EXT_SEH: result = {{48{cut_value[15]}}, cut_value[15:0]};
            default: result = cut_value;
        endcase

        if (ctrl.except) begin
            result = 64'd0;
        end
    end

    assign wr_en = ctrl.valid && ctrl.write_enable;
    assign wr_addr = ctrl.wb_addr;
    assign wr_data = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            except <= 1'b0;
        end else begin
            wb_valid <= ctrl.valid;
            except <= ctrl.valid && ctrl.except;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.valid) begin
            wb_addr <= ctrl.wb_addr;
            wb_data <= result;
        end
    end

endmodule

/* verilog/mips_exec_top.sv */
`timescale 1ns/10ps

module mips_exec_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output logic        wb_valid,
    output logic [4:0]  wb_addr,
    output logic [63:0] wb_data,
    output logic        except
);

    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [63:0] a_data;
    logic [63:0] b_data;
    logic [63:0] shift_out;
    logic [63:0] alu_out;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [63:0] wr_data;

    // registered execute controls
    ex_ctrl_if ctrl ();

    mips_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .ctrl       (ctrl.decoder)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .a_data  (a_data),
        .b_data  (b_data)
    );

    barrel_shifter u_barrel (
        .ctrl      (ctrl.datapath),
        .a_data    (a_data),
        .b_data    (b_data),
        .shift_out (shift_out)
    );

    alu u_alu (
        .ctrl      (ctrl.datapath),
        .a_data    (a_data),
        .b_data    (b_data),
        .shift_out (shift_out),
        .alu_out   (alu_out)
    );

    result_unit u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl.datapath),
        .alu_out   (alu_out),
        .shift_out (shift_out),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .except    (except)
    );

endmodule

/* testbench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [63:0] sext32(input logic [63:0] x);
    return {{32{x[31]}}, x[31:0]};
endfunction

function automatic logic [63:0] rotr64(input logic [63:0] x, input logic [6:0] n);
    return (x >> n) | (x << (7'd64 - n));
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] sa);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_bshfl(input logic [4:0] code, input logic [4:0] rt,
                                          input logic [4:0] rd);
    return {OP_SPECIAL3, 5'd0, rt, rd, code, OP3_FUNC_BSHFL};
endfunction

// expected write-back value from the MIPS64 R6 definitions
function automatic logic [63:0] ref_result(input logic [31:0] w, input logic [63:0] s,
                                           input logic [63:0] t, output logic exc,
                                           output logic [4:0] dest);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  sa;
    logic [63:0] simm;
    logic [63:0] zimm;
    logic [63:0] r;
    logic [6:0]  amt;
    logic [31:0] lo;
    op = w[31:26];
    rs = w[25:21];
    sa = w[10:6];
    fn = w[5:0];
    simm = {{48{w[15]}}, w[15:0]};
    zimm = {48'd0, w[15:0]};
    lo = t[31:0];
    dest = w[15:11];
    exc = 1'b0;
    r = 64'd0;
    if (op == OP_SPECIAL) begin
        exc = (sa != 5'd0);
        case (fn)
            OP0_ADDU:  r = sext32(s + t);
            OP0_DADDU: r = s + t;
            OP0_SUBU:  r = sext32(s - t);
            OP0_DSUBU: r = s - t;
            OP0_AND:   r = s & t;
            OP0_OR:    r = s | t;
            OP0_XOR:   r = s ^ t;
            OP0_NOR:   r = ~(s | t);
            OP0_SLT:   r = {63'd0, $signed(s) < $signed(t)};
            OP0_SLTU:  r = {63'd0, s < t};
            default:   exc = 1'b1;
        endcase
        if (exc) begin
            // shift group, rs selects plain shift or rotate
            exc = (rs != 5'd0);
            amt = {2'd0, sa};
            case (fn)
                OP0_SLL: begin
                    r = sext32({32'd0, lo << sa});
                    exc = exc || (w == 32'd0);
                end
                OP0_SRA:    r = sext32($signed({{32{lo[31]}}, lo}) >>> sa);
                OP0_DSLL:   r = t << sa;
                OP0_DSRA:   r = $signed(t) >>> sa;
                OP0_DSLL32: r = t << (amt + 7'd32);
                OP0_SRL: begin
                    r = (rs == 5'd1) ? sext32({32'd0, (lo >> sa) | (lo << (6'd32 - {1'b0, sa}))})
                                     : sext32({32'd0, lo >> sa});
                    exc = (rs > 5'd1);
                end
                OP0_DSRL: begin
                    r = (rs == 5'd1) ? rotr64(t, amt) : t >> sa;
                    exc = (rs > 5'd1);
                end
                OP0_DSRL32: begin
                    r = (rs == 5'd1) ? rotr64(t, amt + 7'd32) : t >> (amt + 7'd32);
                    exc = (rs > 5'd1);
                end
                OP0_LSA: begin
                    r = sext32((s << ({5'd0, sa[1:0]} + 7'd1)) + t);
                    exc = (sa[4:2] != 3'd0);
                end
                OP0_DLSA: begin
                    r = (s << ({5'd0, sa[1:0]} + 7'd1)) + t;
                    exc = (sa[4:2] != 3'd0);
                end
                default: exc = 1'b1;
            endcase
        end
    end else if (op == OP_SPECIAL3) begin
        exc = !(fn == OP3_FUNC_BSHFL && rs == 5'd0 && (sa == OP3_SEB || sa == OP3_SEH));
        r = (sa == OP3_SEB) ? {{56{t[7]}}, t[7:0]} : {{48{t[15]}}, t[15:0]};
    end else begin
        dest = w[20:16];
        case (op)
            OP_ADDIU:  r = sext32(s + simm);
            OP_DADDIU: r = s + simm;
            OP_SLTI:   r = {63'd0, $signed(s) < $signed(simm)};
            OP_SLTIU:  r = {63'd0, s < simm};
            OP_ANDI:   r = s & zimm;
            OP_ORI:    r = s | zimm;
            OP_XORI:   r = s ^ zimm;
            OP_LUI: begin
                r = sext32({32'd0, w[15:0], 16'd0});
                exc = (rs != 5'd0);
            end
            default:   exc = 1'b1;
        endcase
    end
    if (exc) begin
        r = 64'd0;
    end
    return r;
endfunction

// one entry per supported instruction, the last kind is an unsupported word
function automatic logic [31:0] random_inst(input int kind, input logic [31:0] x);
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    rs = {2'd0, x[2:0]};
    rt = {2'd0, x[5:3]};
    rd = {2'd0, x[8:6]};
    sa = x[13:9];
    case (kind)
        0:  return enc_r(OP0_ADDU, rs, rt, rd, 5'd0);
        1:  return enc_r(OP0_DADDU, rs, rt, rd, 5'd0);
        2:  return enc_r(OP0_SUBU, rs, rt, rd, 5'd0);
        3:  return enc_r(OP0_DSUBU, rs, rt, rd, 5'd0);
        4:  return enc_r(OP0_AND, rs, rt, rd, 5'd0);
        5:  return enc_r(OP0_OR, rs, rt, rd, 5'd0);
        6:  return enc_r(OP0_XOR, rs, rt, rd, 5'd0);
        7:  return enc_r(OP0_NOR, rs, rt, rd, 5'd0);
        8:  return enc_r(OP0_SLT, rs, rt, rd, 5'd0);
        9:  return enc_r(OP0_SLTU, rs, rt, rd, 5'd0);
        10: return enc_i(OP_SLTI, rs, rt, x[31:16]);
        11: return enc_i(OP_SLTIU, rs, rt, x[31:16]);
        12: return enc_i(OP_ADDIU, rs, rt, x[31:16]);
        13: return enc_i(OP_DADDIU, rs, rt, x[31:16]);
        14: return enc_i(OP_ANDI, rs, rt, x[31:16]);
        15: return enc_i(OP_ORI, rs, rt, x[31:16]);
        16: return enc_i(OP_XORI, rs, rt, x[31:16]);
        17: return enc_i(OP_LUI, 5'd0, rt, x[31:16]);
        18: return enc_r(OP0_SLL, 5'd0, rt, rd, sa);
        19: return enc_r(OP0_SRL, 5'd0, rt, rd, sa);
        20: return enc_r(OP0_SRA, 5'd0, rt, rd, sa);
        21: return enc_r(OP0_DSLL, 5'd0, rt, rd, sa);
        22: return enc_r(OP0_DSRL, 5'd0, rt, rd, sa);
        23: return enc_r(OP0_DSRA, 5'd0, rt, rd, sa);
        24: return enc_r(OP0_DSLL32, 5'd0, rt, rd, sa);
        25: return enc_r(OP0_DSRL32, 5'd0, rt, rd, sa);
        26: return enc_r(OP0_SRL, 5'd1, rt, rd, sa);
        27: return enc_r(OP0_DSRL, 5'd1, rt, rd, sa);
        28: return enc_r(OP0_DSRL32, 5'd1, rt, rd, sa);
        29: return enc_r(OP0_LSA, rs, rt, rd, {3'd0, sa[1:0]});
        30: return enc_r(OP0_DLSA, rs, rt, rd, {3'd0, sa[1:0]});
        31: return enc_bshfl(OP3_SEB, rt, rd);
        32: return enc_bshfl(OP3_SEH, rt, rd);
        // j opcode
        default: return {6'b000010, x[25:0]};
    endcase
endfunction

`endif

/* testbench/tb_mips_exec.sv */
`timescale 1ns/10ps

module tb_mips_exec import mips_define::*; ();

    localparam int PERIOD = 100;
    localparam int NUM_RANDOM = 60;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [63:0] wb_data;
    logic        except;

    logic [63:0] shadow [32];
    logic [31:0] prog [$];
    logic [31:0] issued_q [$];
    int          issue_cyc_q [$];
    int          cyc = 0;
    logic [31:0] rng = 32'h0386_0663;

    logic [31:0] cur_word;
    int          cur_cyc;
    logic [63:0] exp_data;
    logic        exp_exc;
    logic [4:0]  exp_dest;

    `include "tb_ref_model.svh"

    mips_exec_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .except     (except)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string what);
        $display("%0t: %s", $time, what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run("value check failed");
        end
    endtask

    task automatic build_program();
        // known 64-bit values in r1 to r4
        prog.push_back(enc_i(OP_LUI, 5'd0, 5'd1, 16'h1234));
        prog.push_back(enc_i(OP_ORI, 5'd1, 5'd1, 16'h5678));
        prog.push_back(enc_i(OP_LUI, 5'd0, 5'd2, 16'h8000));
        prog.push_back(enc_i(OP_DADDIU, 5'd2, 5'd2, 16'hffff));
        prog.push_back(enc_i(OP_ORI, 5'd0, 5'd3, 16'hffff));
        prog.push_back(enc_i(OP_DADDIU, 5'd0, 5'd4, 16'hfffb));
        // arithmetic, logic and compares
        prog.push_back(enc_r(OP0_ADDU, 5'd1, 5'd2, 5'd5, 5'd0));
        prog.push_back(enc_r(OP0_DADDU, 5'd1, 5'd2, 5'd6, 5'd0));
        prog.push_back(enc_r(OP0_SUBU, 5'd4, 5'd1, 5'd7, 5'd0));
        prog.push_back(enc_r(OP0_DSUBU, 5'd4, 5'd2, 5'd5, 5'd0));
        prog.push_back(enc_r(OP0_NOR, 5'd1, 5'd3, 5'd6, 5'd0));
        prog.push_back(enc_r(OP0_SLT, 5'd2, 5'd1, 5'd7, 5'd0));
        prog.push_back(enc_r(OP0_SLTU, 5'd2, 5'd1, 5'd7, 5'd0));
        prog.push_back(enc_i(OP_SLTI, 5'd4, 5'd7, 16'hfffd));
        prog.push_back(enc_i(OP_SLTIU, 5'd4, 5'd7, 16'h0005));
        prog.push_back(enc_i(OP_ADDIU, 5'd1, 5'd5, 16'h7fff));
        prog.push_back(enc_i(OP_XORI, 5'd2, 5'd6, 16'ha5a5));
        // shifts and rotates
        prog.push_back(enc_r(OP0_SLL, 5'd0, 5'd1, 5'd5, 5'd4));
        prog.push_back(enc_r(OP0_SRA, 5'd0, 5'd2, 5'd6, 5'd5));
        prog.push_back(enc_r(OP0_DSRA, 5'd0, 5'd2, 5'd7, 5'd9));
        prog.push_back(enc_r(OP0_DSLL32, 5'd0, 5'd1, 5'd5, 5'd3));
        prog.push_back(enc_r(OP0_DSRL32, 5'd0, 5'd2, 5'd6, 5'd1));
        prog.push_back(enc_r(OP0_SRL, 5'd1, 5'd1, 5'd7, 5'd8));
        prog.push_back(enc_r(OP0_DSRL32, 5'd1, 5'd1, 5'd5, 5'd4));
        // lsa, dlsa, seb, seh
        prog.push_back(enc_r(OP0_LSA, 5'd1, 5'd2, 5'd5, 5'd2));
        prog.push_back(enc_r(OP0_DLSA, 5'd2, 5'd1, 5'd6, 5'd3));
        prog.push_back(enc_bshfl(OP3_SEB, 5'd1, 5'd7));
        prog.push_back(enc_bshfl(OP3_SEH, 5'd2, 5'd7));
        // back-to-back dependence and register 0
        prog.push_back(enc_i(OP_DADDIU, 5'd1, 5'd1, 16'h0001));
        prog.push_back(enc_i(OP_DADDIU, 5'd1, 5'd1, 16'h0001));
        prog.push_back(enc_r(OP0_ADDU, 5'd1, 5'd1, 5'd0, 5'd0));
        prog.push_back(enc_r(OP0_DADDU, 5'd0, 5'd1, 5'd6, 5'd0));
        // nop, trapping add into r5, all ones, then read r5 back
        prog.push_back(32'd0);
        prog.push_back(enc_r(6'b100000, 5'd1, 5'd2, 5'd5, 5'd0));
        prog.push_back(32'hffff_ffff);
        prog.push_back(enc_r(OP0_OR, 5'd5, 5'd0, 5'd6, 5'd0));
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng = xorshift(rng);
            prog.push_back(random_inst(int'(rng % 32'd34), xorshift(rng ^ 32'h5a5a_0f0f)));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = 32'd0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 64'd0;
        end
        build_program();
        repeat (4) @(posedge clk);
        #5 rst_n = 1'b1;
        foreach (prog[i]) begin
            @(posedge clk);
            #5;
            inst_valid = 1'b1;
            inst = prog[i];
            issued_q.push_back(prog[i]);
            issue_cyc_q.push_back(cyc);
        end
        @(posedge clk);
        #5;
        inst_valid = 1'b0;
        inst = 32'd0;
        repeat (4) @(posedge clk);
        if (issued_q.size() != 0) begin
            abort_run("instructions still pending at the end of the run");
        end else begin
            $display("No errors");
            $finish;
        end
    end

    // outputs are stable in the middle of the cycle
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (issued_q.size() == 0) begin
                abort_run("wb_valid pulsed with no instruction pending");
            end else begin
                cur_word = issued_q.pop_front();
                cur_cyc = issue_cyc_q.pop_front();
                check_value("wb latency", 64'(cyc - cur_cyc), 64'd2);
                exp_data = ref_result(cur_word, shadow[cur_word[25:21]],
                                      shadow[cur_word[20:16]], exp_exc, exp_dest);
                check_value("except", {63'd0, except}, {63'd0, exp_exc});
                check_value("wb_data", wb_data, exp_data);
                if (!exp_exc) begin
                    check_value("wb_addr", {59'd0, wb_addr}, {59'd0, exp_dest});
                    if (exp_dest != 5'd0) begin
                        shadow[exp_dest] = exp_data;
                    end
                end
            end
        end else if (rst_n && issued_q.size() != 0 && (cyc - issue_cyc_q[0]) > 2) begin
            abort_run("wb_valid missing for an issued instruction");
        end
    end

    initial begin
        #1;
        #((prog.size() + 20) * PERIOD);
        abort_run("timeout, the run did not finish in time");
    end

endmodule

/* project.f */
+incdir+testbench
verilog/mips_define.sv
verilog/structures.sv
verilog/ex_ctrl_if.sv
verilog/mips_decoder.sv
verilog/reg_file.sv
verilog/barrel_shifter.sv
verilog/alu.sv
verilog/result_unit.sv
verilog/mips_exec_top.sv
testbench/tb_mips_exec.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_exec
FILELIST  ?= project.f
LOG       ?= sim.log
SEED_ARGS ?=
OBJ_DIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard testbench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(SEED_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
